// ==== include/bus_defines.svh ====
`ifndef BUS_DEFINES_SVH
`define BUS_DEFINES_SVH

// shared system bus sizing

// bus masters competing for ownership
`define BUS_MASTER_CH 4

// slaves behind the address decoder
`define BUS_SLAVE_CH 8

// word address, byte lanes not carried
`define BUS_ADDR_W 30

// read and write data width
`define BUS_DATA_W 32

// top address bits naming the slave
`define BUS_SLAVE_INDEX_W 3

`endif

// ==== design/bus_pkg.sv ====
`default_nettype none

`include "bus_defines.svh"

package bus_pkg;

	// current bus owner, one per master
	typedef enum logic [1:0] {
		OWNER_M0 = 2'd0, // master 0, reset owner
		OWNER_M1 = 2'd1,
		OWNER_M2 = 2'd2,
		OWNER_M3 = 2'd3
	} bus_owner_t;

	// split view of a word address
	typedef struct packed {
		logic [`BUS_SLAVE_INDEX_W-1:0]             slave_index; // top bits pick the slave
		logic [`BUS_ADDR_W-`BUS_SLAVE_INDEX_W-1:0] offset;      // word inside the slave
	} bus_addr_fields_t;

	// one address word, read raw or as index plus offset
	typedef union packed {
		logic [`BUS_ADDR_W-1:0] raw;    // full word address
		bus_addr_fields_t       fields; // decoder view
	} bus_addr_u;

	// request a master drives toward the shared bus
	typedef struct packed {
		bus_addr_u              addr;    // word address
		logic                   as_n;    // address strobe, low active
		logic                   rw;      // 1 read, 0 write
		logic [`BUS_DATA_W-1:0] wr_data; // write payload
	} bus_mreq_t;

	// answer of one slave
	typedef struct packed {
		logic [`BUS_DATA_W-1:0] rd_data; // read payload
		logic                   rdy_n;   // ready, low active
	} bus_sresp_t;

endpackage

`default_nettype wire

// ==== design/bus_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "bus_defines.svh"

module bus_arbiter (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic [`BUS_MASTER_CH-1:0] req_n,  // low active request per master
	output logic [`BUS_MASTER_CH-1:0] grnt_n, // low active grant per master
	output bus_pkg::bus_owner_t       owner   // registered owner for the mux
);
	import bus_pkg::*;

	bus_owner_t owner_next; // winner of this cycle's search
	logic [1:0] cand;       // master under inspection

	// Rotating priority search. The current owner is checked first, then the
	// masters after it with wraparound, so the owner keeps the bus while it
	// still requests. Walking the distance downward lets the nearest
	// requester overwrite any farther one.
	always_comb begin
		owner_next = owner; // park when nobody asks
		cand       = owner;
		for (int k = `BUS_MASTER_CH - 1; k >= 0; k--) begin
			cand = owner + 2'(k); // wraps over four masters
			if (!req_n[cand]) begin
				owner_next = bus_owner_t'(cand); // nearer one wins
			end
		end
	end

	// ownership register updated one cycle after the sampled request
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			owner <= OWNER_M0; // master 0 parked after reset
		end else begin
			owner <= owner_next;
		end
	end

	// grant decode straight from the owner register
	always_comb begin
		grnt_n = '1; // all grants idle
		case (owner)
			OWNER_M0: begin
				grnt_n[0] = 1'b0; // master 0 owns
			end
			OWNER_M1: begin
				grnt_n[1] = 1'b0; // master 1 owns
			end
			OWNER_M2: begin
				grnt_n[2] = 1'b0; // master 2 owns
			end
			OWNER_M3: begin
				grnt_n[3] = 1'b0; // master 3 owns
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== design/bus_master_mux.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "bus_defines.svh"

module bus_master_mux (
	input  bus_pkg::bus_owner_t                      owner, // from arbiter
	input  bus_pkg::bus_mreq_t [`BUS_MASTER_CH-1:0]  m_req, // every master's request
	output bus_pkg::bus_mreq_t                       m_bus  // shared request to slaves
);
	import bus_pkg::*;

	// Whole struct follows the owner. A non-owner's strobe, address and data
	// are dropped here and never reach the decoder or a slave.
	always_comb begin
		m_bus = m_req[0]; // overridden by the owner below
		case (owner)
			OWNER_M0: begin
				m_bus = m_req[0];
			end
			OWNER_M1: begin
				m_bus = m_req[1];
			end
			OWNER_M2: begin
				m_bus = m_req[2];
			end
			OWNER_M3: begin
				m_bus = m_req[3];
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== design/bus_addr_dec.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "bus_defines.svh"

module bus_addr_dec (
	input  bus_pkg::bus_mreq_t               m_bus,      // shared request
	output logic [`BUS_SLAVE_CH-1:0]         cs_n,       // chip selects, low active
	output logic [`BUS_SLAVE_INDEX_W-1:0]    slave_index // for the response mux
);

	// index taken from the union's split view
	assign slave_index = m_bus.addr.fields.slave_index;

	// one select low, only with the strobe low
	always_comb begin
		cs_n = '1; // nothing selected while as_n high
		if (!m_bus.as_n) begin
			cs_n[slave_index] = 1'b0; // addressed slave
		end
	end

endmodule

`default_nettype wire

// ==== design/bus_slave_mux.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "bus_defines.svh"

module bus_slave_mux (
	input  logic [`BUS_SLAVE_INDEX_W-1:0]           slave_index, // from decoder
	input  logic                                    as_n,        // shared strobe
	input  bus_pkg::bus_sresp_t [`BUS_SLAVE_CH-1:0] s_resp_in,   // every slave's answer
	output bus_pkg::bus_sresp_t                     s_resp       // back to all masters
);
	import bus_pkg::*;

	// idle answer seen by the masters between transfers
	localparam bus_sresp_t RESP_IDLE = '{
		rd_data: {`BUS_DATA_W{1'b0}}, // no data on an idle bus
		rdy_n:   1'b1                 // never ready while idle
	};

	// Only the addressed slave is passed, and only under the strobe, so a
	// slave left driving ready low cannot end someone else's transfer.
	always_comb begin
		if (!as_n) begin
			s_resp = s_resp_in[slave_index]; // selected slave
		end else begin
			s_resp = RESP_IDLE;
		end
	end

endmodule

`default_nettype wire

// ==== design/bus.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "bus_defines.svh"

module bus (
	input  logic                                     clk,
	input  logic                                     rst_n,
	input  logic [`BUS_MASTER_CH-1:0]                req_n,     // master requests, low active
	output logic [`BUS_MASTER_CH-1:0]                grnt_n,    // master grants, low active
	input  bus_pkg::bus_mreq_t [`BUS_MASTER_CH-1:0]  m_req,     // master side requests
	output bus_pkg::bus_mreq_t                       m_bus,     // shared request to slaves
	output logic [`BUS_SLAVE_CH-1:0]                 cs_n,      // slave selects, low active
	input  bus_pkg::bus_sresp_t [`BUS_SLAVE_CH-1:0]  s_resp_in, // slave side responses
	output bus_pkg::bus_sresp_t                      s_resp     // shared response to masters
);
	import bus_pkg::*;

	bus_owner_t                    owner;       // registered owner
	logic [`BUS_SLAVE_INDEX_W-1:0] slave_index; // decoded slave number

	// only clocked block, owner register and grants
	bus_arbiter i_bus_arbiter (
		.clk    (clk),
		.rst_n  (rst_n),
		.req_n  (req_n),
		.grnt_n (grnt_n),
		.owner  (owner)
	);

	// owner's request onto the shared bus
	bus_master_mux i_bus_master_mux (
		.owner (owner),
		.m_req (m_req),
		.m_bus (m_bus)
	);

	// address to chip select
	bus_addr_dec i_bus_addr_dec (
		.m_bus       (m_bus),
		.cs_n        (cs_n),
		.slave_index (slave_index)
	);

	// selected slave back to the masters
	bus_slave_mux i_bus_slave_mux (
		.slave_index (slave_index),
		.as_n        (m_bus.as_n), // gates stray ready
		.s_resp_in   (s_resp_in),
		.s_resp      (s_resp)
	);

endmodule

`default_nettype wire

// ==== testbench/bus_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "bus_defines.svh"

module bus_tb;
	import bus_pkg::*;

	localparam int CLK_PERIOD   = 8;
	localparam int RESET_CYCLES = 5;
	localparam int RESET_CHECKS = 4;    // idle cycles after release
	localparam int RR_CYCLES    = 2000;
	localparam int HOLD_CYCLES  = 41;   // takeover plus holding
	localparam int PARK_CYCLES  = 10;
	localparam int TRAFFIC_LEN  = 500;  // cycles per traffic test
	localparam int TOTAL_CYCLES = RESET_CYCLES + RESET_CHECKS + RR_CYCLES + HOLD_CYCLES
		+ PARK_CYCLES + 3 * TRAFFIC_LEN;

	logic                                 clk;
	logic                                 rst_n;
	logic [`BUS_MASTER_CH-1:0]            req_n;
	logic [`BUS_MASTER_CH-1:0]            grnt_n;
	bus_mreq_t [`BUS_MASTER_CH-1:0]       m_req;
	bus_mreq_t                            m_bus;
	logic [`BUS_SLAVE_CH-1:0]             cs_n;
	bus_sresp_t [`BUS_SLAVE_CH-1:0]       s_resp_in;
	bus_sresp_t                           s_resp;

	integer     seed = 32'ha6b9d52c; // fixed seed
	logic [1:0] model_owner;         // reference owner register
	int         err_count;
	int         check_count;
	int         test_count;

	bus i_bus (
		.clk       (clk),
		.rst_n     (rst_n),
		.req_n     (req_n),
		.grnt_n    (grnt_n),
		.m_req     (m_req),
		.m_bus     (m_bus),
		.cs_n      (cs_n),
		.s_resp_in (s_resp_in),
		.s_resp    (s_resp)
	);

	initial clk = 1'b0;
	always #(CLK_PERIOD / 2) clk = ~clk;

	// one value against its expectation
	task automatic compare(input string name, input logic [63:0] expected,
			input logic [63:0] actual);
		check_count++;
		if (expected !== actual) begin
			err_count++;
			$display("ERROR %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	// first requester walking up from the owner or the parked owner
	function automatic logic [1:0] rotate_owner(input logic [1:0] cur, input logic [3:0] req);
		logic [1:0] cand;
		logic [1:0] pick;
		logic       found;
		pick  = cur;
		found = 1'b0;
		for (int k = 0; k < `BUS_MASTER_CH; k++) begin
			cand = cur + 2'(k); // wraps at four
			if (!found && !req[cand]) begin
				pick  = cand;
				found = 1'b1;
			end
		end
		return pick;
	endfunction

	task automatic randomize_masters();
		logic [31:0] rnd;
		for (int i = 0; i < `BUS_MASTER_CH; i++) begin
			rnd = $random(seed);
			m_req[i].addr.raw = rnd[`BUS_ADDR_W-1:0];
			rnd = $random(seed);
			m_req[i].wr_data = rnd;
			rnd = $random(seed);
			m_req[i].as_n = rnd[0];
			m_req[i].rw   = rnd[1];
		end
	endtask

	task automatic randomize_slaves();
		logic [31:0] rnd;
		for (int j = 0; j < `BUS_SLAVE_CH; j++) begin
			rnd = $random(seed);
			s_resp_in[j].rd_data = rnd;
			rnd = $random(seed);
			s_resp_in[j].rdy_n = rnd[0];
		end
	endtask

	// shared request, selects and response against the model owner
	task automatic check_routing(input string name);
		bus_mreq_t                     exp_bus;
		logic [`BUS_SLAVE_INDEX_W-1:0] idx;
		logic [`BUS_SLAVE_CH-1:0]      exp_cs;
		bus_sresp_t                    exp_resp;
		exp_bus = m_req[model_owner];
		idx = exp_bus.addr.raw[`BUS_ADDR_W-1 -: `BUS_SLAVE_INDEX_W]; // top address bits
		exp_cs = '1;
		exp_resp.rd_data = '0; // idle bus answer
		exp_resp.rdy_n   = 1'b1;
		if (!exp_bus.as_n) begin
			exp_cs   = ~(`BUS_SLAVE_CH'(1) << idx);
			exp_resp = s_resp_in[idx];
		end
		compare({name, " m_bus"}, 64'(exp_bus), 64'(m_bus));
		compare({name, " cs_n"}, 64'(exp_cs), 64'(cs_n));
		compare({name, " s_resp"}, 64'(exp_resp), 64'(s_resp));
	endtask

	// called on a falling edge with the other inputs already driven
	task automatic run_cycle(input string name, input logic [3:0] req);
		logic [1:0]                next_owner;
		logic [`BUS_MASTER_CH-1:0] exp_grnt;
		req_n = req;
		next_owner = rotate_owner(model_owner, req); // sampled at the coming edge
		#1; // combinational paths settled
		check_routing(name);
		@(negedge clk);
		model_owner = next_owner;
		exp_grnt = ~(`BUS_MASTER_CH'(1) << model_owner); // one grant low
		compare({name, " grnt_n"}, 64'(exp_grnt), 64'(grnt_n));
	endtask

	task automatic report_test(input string name, input int errs_before);
		test_count++;
		$display("test %-12s done, %0d errors", name, err_count - errs_before);
	endtask

	task automatic test_reset();
		int errs;
		errs = err_count;
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(negedge clk);
		rst_n = 1'b1;
		model_owner = 2'd0; // master 0 parked
		for (int i = 0; i < RESET_CHECKS; i++) begin
			randomize_masters();
			randomize_slaves();
			for (int m = 0; m < `BUS_MASTER_CH; m++) begin
				m_req[m].as_n = 1'b1; // nobody strobes
			end
			compare("reset grnt_n", 64'(4'b1110), 64'(grnt_n));
			run_cycle("reset", 4'hf);
			compare("reset cs_n idle", 64'(8'hff), 64'(cs_n));
		end
		report_test("reset", errs);
	endtask

	// random requests and traffic with an optional slave index sweep
	task automatic run_traffic(input string name, input int cycles, input bit sweep);
		logic [31:0] rnd;
		int          errs;
		errs = err_count;
		for (int i = 0; i < cycles; i++) begin
			randomize_masters();
			randomize_slaves();
			if (sweep) begin
				for (int m = 0; m < `BUS_MASTER_CH; m++) begin
					m_req[m].addr.fields.slave_index = 3'(i);
				end
			end
			rnd = $random(seed);
			run_cycle(name, rnd[3:0]);
		end
		report_test(name, errs);
	endtask

	task automatic test_hold_park();
		logic [31:0] rnd;
		logic [1:0]  hold;
		logic [3:0]  req;
		logic [3:0]  exp_grnt;
		int          errs;
		errs = err_count;
		rnd = $random(seed);
		hold = rnd[1:0];
		exp_grnt = ~(4'(1) << hold);
		for (int i = 0; i < HOLD_CYCLES + PARK_CYCLES; i++) begin
			randomize_masters();
			randomize_slaves();
			rnd = $random(seed);
			req = (i == 0) ? 4'hf : rnd[3:0]; // lone request to take over
			req[hold] = 1'b0;
			if (i >= HOLD_CYCLES) begin
				req = 4'hf; // nobody asks so the owner parks
			end
			run_cycle("hold_park", req);
			compare("hold_park owner grant", 64'(exp_grnt), 64'(grnt_n));
		end
		report_test("hold_park", errs);
	endtask

	// watchdog sized from the summed test length
	initial begin
		#(2 * TOTAL_CYCLES * CLK_PERIOD);
		$display("timeout: the tests did not finish within %0d ns",
			2 * TOTAL_CYCLES * CLK_PERIOD);
		$display("Something failed");
		$finish;
	end

	initial begin
		rst_n       = 1'b0;
		req_n       = '1;
		m_req       = '0;
		s_resp_in   = '0;
		model_owner = 2'd0;
		err_count   = 0;
		check_count = 0;
		test_count  = 0;
		for (int m = 0; m < `BUS_MASTER_CH; m++) begin
			m_req[m].as_n = 1'b1;
		end
		test_reset();
		run_traffic("round_robin", RR_CYCLES, 1'b0);
		test_hold_park();
		run_traffic("routing", TRAFFIC_LEN, 1'b0);
		run_traffic("slave_select", TRAFFIC_LEN, 1'b1);
		run_traffic("response", TRAFFIC_LEN, 1'b0);
		$display("%0d tests, %0d checks, %0d errors", test_count, check_count, err_count);
		if (err_count == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== bus.f ====
+incdir+include
design/bus_pkg.sv
design/bus_arbiter.sv
design/bus_master_mux.sv
design/bus_addr_dec.sv
design/bus_slave_mux.sv
design/bus.sv
testbench/bus_tb.sv

// ==== Makefile ====
# Verilator build and run of the shared bus testbench

VERILATOR ?= verilator
TOP       ?= bus_tb
FILELIST  ?= bus.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 0
VFLAGS    ?= --binary --timing -j $(JOBS)

SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard include/*.svh)
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run check clean

all: run

build: $(SIM)

# rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	-./$(SIM) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "Everything OK" $(LOG)

check:
	grep -q "Everything OK" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
